// ==== src.f ====
+incdir+test
design/lsu_pkg.sv
design/dbus_pkg.sv
design/dbus_if.sv
design/lsu_ctrl.sv
design/lsu_align.sv
design/data_ram.sv
design/lsu_top.sv
test/lsu_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the lsu testbench with verilator, verdict from the log
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert --top-module lsu_tb -f src.f
./obj_dir/Vlsu_tb > sim.log 2>&1 || true
cat sim.log
if grep -q "STATUS: FAIL" sim.log; then
   exit 1
fi
grep -q "STATUS: PASS" sim.log

// ==== test/lsu_tb_model.svh ====
/*
   load/store unit reference model
   xorshift generator and shadow data memory
   opcode decode, store merge, expected load value
*/

logic [31:0] shadow_mem [ram_depth];   // one entry per data_ram word

// 32-bit xorshift, shifts 13 17 5
function automatic logic [31:0] xorshift32(input logic [31:0] x);
   logic [31:0] y;
   y = x ^ (x << 13);
   y = y ^ (y >> 17);
   y = y ^ (y << 5);
   return y;
endfunction

function automatic logic is_load(input logic [5:0] opc);
   return opc == opc_lwz || opc == opc_lws || opc == opc_lbz ||
          opc == opc_lbs || opc == opc_lhz || opc == opc_lhs;
endfunction

// bytes moved by the access
function automatic int op_size(input logic [5:0] opc);
   case (opc)
      opc_lbz, opc_lbs, opc_sb: return 1;
      opc_lhz, opc_lhs, opc_sh: return 2;
      default:                  return 4;
   endcase
endfunction

// big-endian lanes, offset 0 is bits 31:24
function automatic void shadow_store(input logic [7:0] idx, input logic [5:0] opc,
                                     input logic [1:0] ofs, input logic [31:0] data);
   logic [31:0] w;
   w = shadow_mem[idx];
   if (op_size(opc) == 1)
   begin
      case (ofs)
         2'd0:    w[31:24] = data[7:0];
         2'd1:    w[23:16] = data[7:0];
         2'd2:    w[15:8]  = data[7:0];
         default: w[7:0]   = data[7:0];
      endcase
   end
   else if (op_size(opc) == 2)
   begin
      if (ofs[1])
         w[15:0] = data[15:0];               // low half
      else
         w[31:16] = data[15:0];
   end
   else
      w = data;
   shadow_mem[idx] = w;
endfunction

function automatic logic [31:0] expected_load(input logic [31:0] word,
                                              input logic [5:0]  opc,
                                              input logic [1:0]  ofs);
   logic [7:0]  byte_v;
   logic [15:0] half_v;
   case (ofs)
      2'd0:    byte_v = word[31:24];
      2'd1:    byte_v = word[23:16];
      2'd2:    byte_v = word[15:8];
      default: byte_v = word[7:0];
   endcase
   half_v = ofs[1] ? word[15:0] : word[31:16];
   case (opc)
      opc_lbz: return {24'h0, byte_v};
      opc_lbs: return {{24{byte_v[7]}}, byte_v};   // sign from lane msb
      opc_lhz: return {16'h0, half_v};
      opc_lhs: return {{16{half_v[15]}}, half_v};
      default: return word;                         // lwz and lws alike
   endcase
endfunction

// ==== test/lsu_tb.sv ====
/*
   load/store unit testbench
   clock, reset, op sequencing, answer checker, watchdog
   directed and random tests against the shadow model
*/
`timescale 1ns/100ps

module lsu_tb
   import lsu_pkg::*, dbus_pkg::*;
();

   localparam logic [31:0] seed            = 32'd76720;
   localparam int          directed_ops    = 60;
   localparam int          init_ops        = 32;    // fill of words 0 to 31
   localparam int          random_ops      = 300;
   localparam int          total_ops       = directed_ops + init_ops + random_ops;
   localparam int          watchdog_cycles = total_ops * 4 + 100;
   localparam int          answer_timeout  = 8;     // cycles allowed for valid_o

   logic        clk = 1'b0;
   logic        rst;
   logic        padv_i;
   logic        op_load_i;
   logic        op_store_i;
   logic [5:0]  opc_i;
   logic [31:0] adr_i;
   logic [31:0] wdat_i;
   logic        exception_taken_i;
   logic [31:0] result_o;
   logic        valid_o;
   logic        except_align_o;
   logic        except_dbus_o;

   logic [1:0]  op_age;        // 1 req cycle, 2 answer, 3 hold, 0 idle
   logic        exp_load;      // result compared only for good loads
   logic        exp_align;
   logic        exp_dbus;
   logic [31:0] exp_result;

   `include "lsu_tb_model.svh"

   lsu_top dut_i (
      .clk               (clk),
      .rst               (rst),
      .padv_i            (padv_i),
      .op_load_i         (op_load_i),
      .op_store_i        (op_store_i),
      .opc_i             (opc_i),
      .adr_i             (adr_i),
      .wdat_i            (wdat_i),
      .exception_taken_i (exception_taken_i),
      .result_o          (result_o),
      .valid_o           (valid_o),
      .except_align_o    (except_align_o),
      .except_dbus_o     (except_dbus_o)
   );

   always #5 clk = ~clk;   // 10 ns period

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp)
      begin
         $display("Fail %s: got 0x%08h expected 0x%08h", name, got, exp);
         $display("STATUS: FAIL");
         $fatal(1, "value mismatch on %s", name);
      end
   endtask

   task automatic stop_on_error(input string why);
      $display("%s", why);
      $display("STATUS: FAIL");
      $fatal(1, "run aborted");
   endtask

   function automatic logic [5:0] pick_opcode(input logic [31:0] r);
      int sel;
      sel = int'(r % 32'd9);
      case (sel)
         0: return opc_lwz;
         1: return opc_lws;
         2: return opc_lbz;
         3: return opc_lbs;
         4: return opc_lhz;
         5: return opc_lhs;
         6: return opc_sw;
         7: return opc_sb;
         default: return opc_sh;
      endcase
   endfunction

   // starts and ends 1 ns after a rising edge, four cycles per op
   task automatic do_access(input logic [5:0] opc, input logic [31:0] adr,
                            input logic [31:0] data);
      logic load;
      logic misalign;
      logic outside;
      int   sz;
      int   wait_cycles;
      load     = is_load(opc);
      sz       = op_size(opc);
      misalign = (sz == 4 && adr[1:0] != 2'b00) || (sz == 2 && adr[0]);
      outside  = ~misalign & ({2'b00, adr[31:2]} >= 32'(ram_depth));   // word index
      exp_load   = load & ~misalign & ~outside;
      exp_align  = misalign;
      exp_dbus   = outside;
      exp_result = expected_load(shadow_mem[adr[9:2]], opc, adr[1:0]);
      if (!load && !misalign && !outside)
         shadow_store(adr[9:2], opc, adr[1:0], data);
      op_load_i  = load;
      op_store_i = ~load;
      opc_i      = opc;
      adr_i      = adr;
      wdat_i     = data;
      padv_i     = 1'b1;
      @(posedge clk);
      #1;
      padv_i = 1'b0;                      // single advance pulse
      wait_cycles = 0;
      @(negedge clk);
      while (!valid_o && wait_cycles < answer_timeout)
      begin
         @(negedge clk);
         wait_cycles++;
      end
      if (!valid_o)
         stop_on_error("valid_o did not rise after padv_i");
      @(negedge clk);                     // hold cycle compared by the checker
      @(posedge clk);
      #1;
   endtask

   // every legal byte and halfword offset plus the word
   task automatic load_all_offsets(input logic [31:0] base);
      for (int o = 0; o < 4; o++)
      begin
         do_access(opc_lbz, base + 32'(o), 32'h0);
         do_access(opc_lbs, base + 32'(o), 32'h0);
      end
      for (int o = 0; o < 4; o += 2)
      begin
         do_access(opc_lhz, base + 32'(o), 32'h0);
         do_access(opc_lhs, base + 32'(o), 32'h0);
      end
      do_access(opc_lwz, base, 32'h0);
      do_access(opc_lws, base, 32'h0);
   endtask

   task automatic take_exception();
      @(negedge clk);
      check_value("except_dbus_o", 32'(except_dbus_o), 32'h1);   // still pending
      @(posedge clk);
      #1;
      exception_taken_i = 1'b1;
      @(posedge clk);
      #1;
      exception_taken_i = 1'b0;
      @(negedge clk);
      check_value("except_dbus_o", 32'(except_dbus_o), 32'h0);
      @(posedge clk);
      #1;
   endtask

   always @(posedge clk)
      if (rst)
         op_age <= 2'd0;
      else if (padv_i)
         op_age <= 2'd1;
      else if (op_age != 2'd0)
         op_age <= op_age + 2'd1;         // wraps to idle after hold

   // outputs settle well before the falling edge
   always @(negedge clk)
   begin
      if (op_age == 2'd1)
      begin
         check_value("valid_o", 32'(valid_o), 32'h0);     // not before cycle 2
         check_value("except_align_o", 32'(except_align_o), 32'h0);
         check_value("except_dbus_o", 32'(except_dbus_o), 32'h0);
      end
      if (op_age == 2'd2 || op_age == 2'd3)
      begin
         check_value("valid_o", 32'(valid_o), 32'h1);
         check_value("except_align_o", 32'(except_align_o), 32'(exp_align));
         check_value("except_dbus_o", 32'(except_dbus_o), 32'(exp_dbus));
         if (exp_load)
            check_value("result_o", result_o, exp_result);   // same value when held
      end
   end

   initial
   begin
      repeat (watchdog_cycles) @(posedge clk);
      stop_on_error("watchdog expired before the test sequence finished");
   end

   initial
   begin
      logic [31:0] rnd;
      logic [5:0]  opc;
      logic [1:0]  ofs;
      rst               = 1'b1;
      padv_i            = 1'b0;
      op_load_i         = 1'b0;
      op_store_i        = 1'b0;
      opc_i             = '0;
      adr_i             = '0;
      wdat_i            = '0;
      exception_taken_i = 1'b0;
      exp_load          = 1'b0;
      exp_align         = 1'b0;
      exp_dbus          = 1'b0;
      exp_result        = '0;
      rnd               = seed;
      for (int i = 0; i < ram_depth; i++)
         shadow_mem[i] = '0;
      repeat (10) @(posedge clk);
      #1;
      rst = 1'b0;
      @(negedge clk);
      check_value("valid_o", 32'(valid_o), 32'h0);
      check_value("except_align_o", 32'(except_align_o), 32'h0);
      check_value("except_dbus_o", 32'(except_dbus_o), 32'h0);
      @(posedge clk);
      #1;

      // word store and load, also the last word of the memory
      do_access(opc_sw, 32'h0A0, 32'h1234_5678);
      do_access(opc_lwz, 32'h0A0, 32'h0);
      do_access(opc_sw, 32'h3FC, 32'hF00D_BEEF);
      do_access(opc_lwz, 32'h3FC, 32'h0);
      do_access(opc_lws, 32'h3FC, 32'h0);

      // byte and halfword merges, junk in the unused upper bits
      do_access(opc_sw, 32'h0A4, 32'h0000_0000);
      do_access(opc_sb, 32'h0A4, 32'hABCD_EF9C);
      do_access(opc_sb, 32'h0A5, 32'h1234_5641);
      do_access(opc_sb, 32'h0A6, 32'h0000_00E7);
      do_access(opc_sb, 32'h0A7, 32'hFFFF_FF05);
      do_access(opc_lwz, 32'h0A4, 32'h0);
      do_access(opc_sh, 32'h0A6, 32'h5555_8001);
      do_access(opc_lwz, 32'h0A4, 32'h0);
      load_all_offsets(32'h0A4);
      do_access(opc_sh, 32'h0A4, 32'h1234_7FFE);
      do_access(opc_lwz, 32'h0A4, 32'h0);
      load_all_offsets(32'h0A4);

      // misaligned word and halfword accesses leave memory alone
      do_access(opc_sw, 32'h0A8, 32'hCAFE_F00D);
      do_access(opc_sw, 32'h0A9, 32'h1111_1111);
      do_access(opc_sw, 32'h0AA, 32'h2222_2222);
      do_access(opc_sw, 32'h0AB, 32'h3333_3333);
      do_access(opc_sh, 32'h0A9, 32'h4444_4444);
      do_access(opc_sh, 32'h0AB, 32'h5555_5555);
      do_access(opc_lwz, 32'h0AA, 32'h0);
      do_access(opc_lws, 32'h0A9, 32'h0);
      do_access(opc_lhz, 32'h0A9, 32'h0);
      do_access(opc_lhs, 32'h0AB, 32'h0);
      do_access(opc_lwz, 32'h0A8, 32'h0);

      // word index 256 and up, 0x400 aliases word 0 in the array
      do_access(opc_sw, 32'h000, 32'h5A5A_0FF0);
      do_access(opc_sw, 32'h400, 32'hDEAD_DEAD);
      take_exception();
      do_access(opc_lwz, 32'h400, 32'h0);
      take_exception();
      do_access(opc_sh, 32'hFFFF_FFFE, 32'h0000_1234);
      take_exception();
      do_access(opc_lbz, 32'h7FFF_FFF1, 32'h0);
      take_exception();
      do_access(opc_lwz, 32'h000, 32'h0);

      // random mix on words 0 to 31
      for (int i = 0; i < init_ops; i++)
      begin
         rnd = xorshift32(rnd);
         do_access(opc_sw, 32'(i * 4), rnd);
      end
      for (int n = 0; n < random_ops; n++)
      begin
         rnd = xorshift32(rnd);
         opc = pick_opcode(rnd);
         rnd = xorshift32(rnd);
         case (op_size(opc))
            1:       ofs = rnd[9:8];
            2:       ofs = {rnd[9], 1'b0};
            default: ofs = 2'b00;
         endcase
         do_access(opc, {25'h0, rnd[4:0], ofs}, xorshift32(rnd));
         rnd = xorshift32(rnd);
      end

      @(posedge clk);
      $display("STATUS: PASS");
      $finish;
   end

endmodule

// ==== design/lsu_top.sv ====
/*
   load/store unit top level
   sequencing, lane datapath and data memory on one data bus
*/
`timescale 1ns/100ps

module lsu_top
   import lsu_pkg::*;
(
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     padv_i,             // pipeline advance
   input  logic                     op_load_i,
   input  logic                     op_store_i,
   input  logic [opcode_width-1:0]  opc_i,
   input  logic [operand_width-1:0] adr_i,              // effective address
   input  logic [operand_width-1:0] wdat_i,             // store data
   input  logic                     exception_taken_i,
   output logic [operand_width-1:0] result_o,
   output logic                     valid_o,
   output logic                     except_align_o,
   output logic                     except_dbus_o
);

   dbus_if dbus ();

   logic [operand_width-1:0] adr_r;        // registered address
   logic                     done;

   lsu_ctrl ctrl_i (
      .clk               (clk),
      .rst               (rst),
      .padv_i            (padv_i),
      .op_load_i         (op_load_i),
      .op_store_i        (op_store_i),
      .opc_i             (opc_i),
      .adr_i             (adr_i),
      .exception_taken_i (exception_taken_i),
      .bus               (dbus.ctrl),
      .adr_r_o           (adr_r),
      .done_o            (done),
      .valid_o           (valid_o),
      .except_align_o    (except_align_o),
      .except_dbus_o     (except_dbus_o)
   );

   lsu_align align_i (
      .clk        (clk),
      .op_load_i  (op_load_i),
      .op_store_i (op_store_i),
      .opc_i      (opc_i),
      .wdat_i     (wdat_i),
      .adr_r_i    (adr_r),
      .done_i     (done),
      .bus        (dbus.lane),
      .result_o   (result_o)
   );

   data_ram ram_i (
      .clk (clk),
      .rst (rst),
      .bus (dbus.slave)
   );

endmodule

// ==== design/data_ram.sv ====
/*
   single-port data memory on the data bus
   byte-lane writes, registered read data
   one-cycle ack, err for word index beyond the array
*/
`timescale 1ns/100ps

module data_ram
   import dbus_pkg::*;
(
   input  logic  clk,
   input  logic  rst,
   dbus_if.slave bus
);

   dbus_word_u                  mem [ram_depth];
   dbus_word_u                  rdat_r;
   logic [dbus_adr_width-3:0]   word_idx;    // byte address / 4
   logic [ram_adr_width-1:0]    widx;        // array index, adr 9:2
   logic                        in_range;
   logic                        take;        // first cycle of a request
   logic                        ack_r;
   logic                        err_r;

   assign word_idx = bus.adr[dbus_adr_width-1:2];
   assign widx     = word_idx[ram_adr_width-1:0];
   assign in_range = word_idx <= (dbus_adr_width-2)'(ram_depth - 1);

   // no second answer while the master is still dropping req
   assign take = bus.req & ~ack_r & ~err_r;

   always_ff @(posedge clk)
      if (rst)
      begin
         ack_r <= 1'b0;
         err_r <= 1'b0;
      end
      else
      begin
         ack_r <= take & in_range;
         err_r <= take & ~in_range;          // access itself dropped
      end

   // lane writes, only selected bytes change
   always_ff @(posedge clk)
      if (take & in_range & bus.we)
         for (int i = 0; i < bsel_width; i++)
            if (bus.bsel[i])
               mem[widx].b[i] <= bus.wdat.b[i];

   // read every taken cycle, old data on a write
   always_ff @(posedge clk)
      if (take)
         rdat_r <= mem[widx];

   assign bus.rdat = rdat_r;
   assign bus.ack  = ack_r;
   assign bus.err  = err_r;

   // master lets go of req on the answering cycle
   a_req_dropped_on_answer: assert property (
      @(posedge clk) disable iff (rst) (bus.ack || bus.err) |-> !bus.req);

endmodule

// ==== design/lsu_align.sv ====
/*
   load/store data path
   big-endian byte selects and store lane replication
   load alignment, sign/zero extension, result register
*/
`timescale 1ns/100ps

module lsu_align
   import lsu_pkg::*, dbus_pkg::*;
(
   input  logic                     clk,
   input  logic                     op_load_i,
   input  logic                     op_store_i,
   input  logic [opcode_width-1:0]  opc_i,
   input  logic [operand_width-1:0] wdat_i,      // store operand
   input  logic [operand_width-1:0] adr_r_i,     // address as on the bus
   input  logic                     done_i,
   dbus_if.lane                     bus,
   output logic [operand_width-1:0] result_o
);

   logic [0:bsel_width-1]    bsel;
   dbus_word_u               wdat_rep;      // store data on every lane
   dbus_word_u               rd_shift;      // addressed byte moved to lane 0
   logic [operand_width-1:0] extended;
   logic [operand_width-1:0] result_r;      // held load result

   // byte selects, lane 0 at offset 0
   always_comb
   begin
      bsel = '0;                            // idle
      if (op_load_i | op_store_i)
      begin
         case (opc_i)
            opc_lbz, opc_lbs, opc_sb:
               bsel = 4'b1000 >> adr_r_i[1:0];
            opc_lhz, opc_lhs, opc_sh:
               bsel = adr_r_i[1] ? 4'b0011 : 4'b1100;
            default:
               bsel = 4'b1111;              // word
         endcase
      end
   end

   // replicate so the memory picks its lanes by bsel alone
   always_comb
   begin
      wdat_rep.w = wdat_i;                  // sw as is
      case (opc_i)
         opc_sb:
            for (int i = 0; i < bsel_width; i++)
               wdat_rep.b[i] = wdat_i[byte_width-1:0];
         opc_sh:
            for (int i = 0; i < bsel_width; i++)
               wdat_rep.b[i] = i[0] ? wdat_i[byte_width-1:0]
                                    : wdat_i[2*byte_width-1:byte_width];
         default:
            wdat_rep.w = wdat_i;
      endcase
   end

   assign bus.bsel = bsel;
   assign bus.wdat = wdat_rep;

   // registered address is stable by the time rdat comes back
   assign rd_shift.w = bus.rdat.w << {adr_r_i[1:0], 3'b000};

   always_comb
   begin
      case (opc_i)
         opc_lbz:
            extended = {{(operand_width-byte_width){1'b0}}, rd_shift.b[0]};
         opc_lbs:
            extended = {{(operand_width-byte_width){rd_shift.b[0][byte_width-1]}},
                        rd_shift.b[0]};
         opc_lhz:
            extended = {{(operand_width-2*byte_width){1'b0}},
                        rd_shift.b[0], rd_shift.b[1]};
         opc_lhs:
            extended = {{(operand_width-2*byte_width){rd_shift.b[0][byte_width-1]}},
                        rd_shift.b[0], rd_shift.b[1]};
         default:
            extended = rd_shift.w;          // lwz, lws, offset is 0
      endcase
   end

   always_ff @(posedge clk)
      if (bus.ack & op_load_i)
         result_r <= extended;

   // straight through on the ack cycle, then the captured value
   assign result_o = done_i ? result_r : extended;

endmodule

// ==== design/lsu_ctrl.sv ====
/*
   load/store sequencing
   address register, bus request, done flag
   alignment and bus error exceptions, valid output
*/
`timescale 1ns/100ps

module lsu_ctrl
   import lsu_pkg::*;
(
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     padv_i,
   input  logic                     op_load_i,
   input  logic                     op_store_i,
   input  logic [opcode_width-1:0]  opc_i,
   input  logic [operand_width-1:0] adr_i,
   input  logic                     exception_taken_i,
   dbus_if.ctrl                     bus,
   output logic [operand_width-1:0] adr_r_o,
   output logic                     done_o,
   output logic                     valid_o,
   output logic                     except_align_o,
   output logic                     except_dbus_o
);

   logic                     op_lsu;          // load or store presented
   logic                     busy;            // op issued, no answer yet
   logic                     done_r;          // answered, hold result
   logic                     word_op;
   logic                     half_op;
   logic                     align_err;       // from registered address
   logic                     align_hit;       // misaligned op in flight
   logic                     except_align_r;
   logic                     except_dbus_r;   // sticky bus error
   logic [operand_width-1:0] adr_r;

   assign op_lsu  = op_load_i | op_store_i;

   assign word_op = (opc_i == opc_lwz) | (opc_i == opc_lws) | (opc_i == opc_sw);
   assign half_op = (opc_i == opc_lhz) | (opc_i == opc_lhs) | (opc_i == opc_sh);

   // bytes can sit anywhere
   assign align_err = op_lsu & ((word_op & |adr_r[1:0]) | (half_op & adr_r[0]));
   assign align_hit = busy & align_err;

   // address captured on advance, stays on the bus until the next one
   always_ff @(posedge clk)
      if (padv_i & op_lsu)
         adr_r <= adr_i;

   always_ff @(posedge clk)
      if (rst)
         busy <= 1'b0;
      else if (padv_i)
         busy <= op_lsu;
      else if (bus.ack | bus.err | align_hit)
         busy <= 1'b0;                          // answered or never issued

   always_ff @(posedge clk)
      if (rst)
         done_r <= 1'b0;
      else if (padv_i)
         done_r <= 1'b0;
      else if (bus.ack | bus.err | align_hit)
         done_r <= 1'b1;

   always_ff @(posedge clk)
      if (rst)
         except_align_r <= 1'b0;
      else if (exception_taken_i | padv_i)
         except_align_r <= 1'b0;
      else if (align_hit)
         except_align_r <= 1'b1;

   // held across advances until the exception is taken
   always_ff @(posedge clk)
      if (rst)
         except_dbus_r <= 1'b0;
      else if (exception_taken_i)
         except_dbus_r <= 1'b0;
      else if (bus.err)
         except_dbus_r <= 1'b1;

   // req drops on the answering cycle itself
   assign bus.req = busy & ~align_err & ~bus.ack & ~bus.err;
   assign bus.adr = adr_r;
   assign bus.we  = op_store_i;

   assign adr_r_o        = adr_r;
   assign done_o         = done_r;
   assign valid_o        = done_r | bus.ack | bus.err;   // answer cycle, then held
   assign except_align_o = except_align_r;
   assign except_dbus_o  = except_dbus_r | bus.err;

   // a misaligned access never reaches the memory, so nothing answers it
   a_no_answer_misaligned: assert property (
      @(posedge clk) disable iff (rst) except_align_o |-> !(bus.ack || bus.err));

   // memory answers only a request seen the cycle before
   a_ack_follows_req: assert property (
      @(posedge clk) disable iff (rst) bus.ack |-> $past(bus.req));

endmodule

// ==== design/dbus_if.sv ====
/*
   data bus between load/store unit and data memory
   ctrl and lane modports for the two master halves, slave modport
*/
`timescale 1ns/100ps

interface dbus_if
   import dbus_pkg::*;
();

   logic [dbus_adr_width-1:0] adr;     // byte address, held while req
   logic                      req;
   logic                      we;      // 1 = write
   logic [0:bsel_width-1]     bsel;    // bit 0 = lane 0 = msb lane
   dbus_word_u                wdat;
   dbus_word_u                rdat;    // valid with ack
   logic                      ack;     // one cycle
   logic                      err;     // one cycle, instead of ack

   // sequencing half of the master
   modport ctrl (output adr, req, we, input ack, err);

   // data path half of the master
   modport lane (output bsel, wdat, input rdat, ack);

   modport slave (input adr, req, we, bsel, wdat, output rdat, ack, err);

endinterface

// ==== design/dbus_pkg.sv ====
/*
   data bus definitions
   lane count, address width, data memory depth
   bus word union with word and byte lane views
*/
package dbus_pkg;

   localparam int byte_width     = 8;
   localparam int bsel_width     = 4;     // byte lanes per word
   localparam int dbus_adr_width = 32;    // byte address
   localparam int ram_depth      = 256;   // words
   localparam int ram_adr_width  = 8;     // word index bits

   // big-endian, lane 0 holds bits 31:24
   typedef union packed {
      logic [bsel_width*byte_width-1:0]      w;   // whole word
      logic [0:bsel_width-1][byte_width-1:0] b;   // byte lanes, msb first
   } dbus_word_u;

endpackage

// ==== design/lsu_pkg.sv ====
/*
   load/store unit definitions
   operand and opcode widths
   load opcodes (byte, halfword, word with zero or sign extension)
   store opcodes (byte, halfword, word)
*/
package lsu_pkg;

   localparam int operand_width = 32;   // gpr and address width
   localparam int opcode_width  = 6;    // major opcode field

   // loads
   localparam logic [opcode_width-1:0] opc_lwz = 6'h21;   // word, zero ext
   localparam logic [opcode_width-1:0] opc_lws = 6'h22;   // word, sign ext
   localparam logic [opcode_width-1:0] opc_lbz = 6'h23;   // byte, zero ext
   localparam logic [opcode_width-1:0] opc_lbs = 6'h24;   // byte, sign ext
   localparam logic [opcode_width-1:0] opc_lhz = 6'h25;   // halfword, zero ext
   localparam logic [opcode_width-1:0] opc_lhs = 6'h26;   // halfword, sign ext

   // stores
   // low bits pick the size, 01 word, 10 byte, 11 halfword
   localparam logic [opcode_width-1:0] opc_sw  = 6'h35;
   localparam logic [opcode_width-1:0] opc_sb  = 6'h36;
   localparam logic [opcode_width-1:0] opc_sh  = 6'h37;

endpackage
